// File: spi_cfg.svh
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// character lane, wide enough for the longest character
`define SPI_LANE_BITS    16

// packed word assembled by the slave
`define SPI_WORD_BITS    32

// entries in the slave transmit table
`define SPI_TX_DEPTH     8

// system clocks per sck half period
`define SPI_HALF_DIV     4

// flops on sck, cs and mosi in the slave
`define SPI_SYNC_STAGES  2

`endif

// File: spi_mode_pkg.sv
package spi_mode_pkg;

    // number of bits in a character minus one
    typedef logic [3:0] char_len_t;

    // bus mode shared by master and slave
    typedef struct packed {
        logic cpol;   // sck idle level
        logic cpha;   // sample on second edge
        logic cspol;  // cs active low
        logic rev;    // lsb first
    } spi_mode_t;

    // characters longer than eight bits use the full 16-bit lane;
    // shorter ones sit zero-extended in an 8-bit lane
    function automatic logic wide_lane(char_len_t len);
        logic wide;
        wide = (len > 4'd7);
        return wide;
    endfunction

endpackage

// File: spi_data_pkg.sv
`include "spi_cfg.svh"

package spi_data_pkg;

    // one character as it travels on the lane
    typedef logic [`SPI_LANE_BITS-1:0] spi_char_t;

    // packed word, two 16-bit or four 8-bit lanes
    typedef logic [`SPI_WORD_BITS-1:0] spi_word_t;

    // address into the transmit table
    typedef logic [$clog2(`SPI_TX_DEPTH)-1:0] tx_idx_t;

endpackage

// File: spi_master_char.sv
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_master_char (
    input  logic                    S_SYSCLK,
    input  logic                    arst_n,
    input  spi_mode_pkg::spi_mode_t mode,
    input  spi_mode_pkg::char_len_t char_len,
    input  logic                    m_start,
    input  logic                    m_hold,
    input  spi_data_pkg::spi_char_t m_tx_char,
    output logic                    m_busy,
    output logic                    m_done,
    output spi_data_pkg::spi_char_t m_rx_char,
    output logic                    spi_sck,
    output logic                    spi_cs,
    output logic                    spi_mosi,
    input  logic                    spi_miso
);

    import spi_mode_pkg::*;
    import spi_data_pkg::*;

    localparam int DIV_W = $clog2(`SPI_HALF_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic [5:0]       edge_cnt;     // sck edges issued so far
    logic [5:0]       edge_total;
    logic             sck_tgl;      // high between leading and trailing edge
    logic             cs_act;
    logic             hold_q;       // keep cs after this character
    logic             half_tick;
    logic             last_half;
    logic             sample_edge;
    char_len_t        tx_bit;
    char_len_t        rx_bit;
    char_len_t        tx_idx;
    char_len_t        rx_idx;
    spi_char_t        tx_sr;

    assign edge_total  = {1'b0, char_len, 1'b1} + 6'd1;  // two per bit
    assign half_tick   = (div_cnt == DIV_W'(`SPI_HALF_DIV - 1));
    assign last_half   = (edge_cnt == edge_total);
    assign sample_edge = mode.cpha ? sck_tgl : ~sck_tgl;  // next edge samples
    assign tx_idx      = mode.rev ? tx_bit : char_len - tx_bit;
    assign rx_idx      = mode.rev ? rx_bit : char_len - rx_bit;

    assign spi_sck  = sck_tgl ^ mode.cpol;
    assign spi_cs   = cs_act ^ mode.cspol;
    assign spi_mosi = cs_act & tx_sr[tx_idx];

    always_ff @(posedge S_SYSCLK or negedge arst_n) begin
        if (!arst_n) begin
            m_busy   <= 1'b0;
            m_done   <= 1'b0;
            cs_act   <= 1'b0;
            hold_q   <= 1'b0;
            sck_tgl  <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= '0;
            tx_bit   <= '0;
            rx_bit   <= '0;
        end else begin
            m_done <= 1'b0;
            if (!m_busy) begin
                if (m_start) begin
                    m_busy   <= 1'b1;
                    cs_act   <= 1'b1;
                    hold_q   <= m_hold;
                    div_cnt  <= '0;
                    edge_cnt <= '0;
                    tx_bit   <= '0;
                    rx_bit   <= '0;
                end
            end else if (!half_tick) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt <= '0;
                if (last_half) begin
                    m_busy <= 1'b0;
                    m_done <= 1'b1;
                    cs_act <= hold_q;  // drop cs unless held
                end else begin
                    sck_tgl  <= ~sck_tgl;
                    edge_cnt <= edge_cnt + 1'b1;
                    if (sample_edge) begin
                        rx_bit <= (rx_bit == char_len) ? '0 : rx_bit + 1'b1;
                    end else if (rx_bit != '0) begin
                        tx_bit <= tx_bit + 1'b1;  // no shift before first sample
                    end
                end
            end
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (!m_busy && m_start) begin
            tx_sr     <= m_tx_char;
            m_rx_char <= '0;  // short characters read zero-extended
        end else if (m_busy && half_tick && !last_half && sample_edge) begin
            m_rx_char[rx_idx] <= spi_miso;
        end
    end

endmodule

// File: spi_slave_trx_char.sv
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_slave_trx_char (
    input  logic                    S_SYSCLK,
    input  logic                    arst_n,
    input  logic                    enable,
    input  spi_mode_pkg::spi_mode_t mode,
    input  spi_mode_pkg::char_len_t char_len,
    input  logic                    spi_cs,
    input  logic                    spi_sck,
    input  logic                    spi_mosi,
    output logic                    spi_miso,
    output logic                    slv_active,
    output logic                    slv_char_done,
    input  spi_data_pkg::spi_char_t s_wchar,
    output spi_data_pkg::spi_char_t slv_rx_char
);

    import spi_mode_pkg::*;
    import spi_data_pkg::*;

    localparam int SYNC = `SPI_SYNC_STAGES;

    logic [SYNC-1:0] sck_sync;
    logic [SYNC-1:0] cs_sync;
    logic [SYNC-1:0] mosi_sync;
    logic            sck_prev;
    logic            cs_on_q;
    logic            done_d;      // packer has updated s_wchar
    logic            sck_s;
    logic            cs_on;
    logic            sck_edge;
    logic            lead_lvl;
    logic            sample_edge;
    logic            shift_edge;
    logic            load;
    char_len_t       bit_cnt;
    char_len_t       tx_bit;
    char_len_t       tx_idx;
    char_len_t       rx_idx;
    spi_char_t       w_sr;
    spi_char_t       rx_next;

    assign sck_s       = sck_sync[SYNC-1];
    assign cs_on       = enable & (cs_sync[SYNC-1] ^ mode.cspol);
    assign slv_active  = cs_on;
    assign sck_edge    = sck_s ^ sck_prev;
    assign lead_lvl    = sck_s ^ mode.cpol;  // sck away from idle
    assign sample_edge = cs_on & sck_edge & (mode.cpha ? ~lead_lvl : lead_lvl);
    assign shift_edge  = cs_on & sck_edge & (mode.cpha ? lead_lvl : ~lead_lvl)
                         & (bit_cnt != '0);
    assign load        = cs_on & (~cs_on_q | done_d);  // frame start or next char
    assign tx_idx      = mode.rev ? tx_bit : char_len - tx_bit;
    assign rx_idx      = mode.rev ? bit_cnt : char_len - bit_cnt;
    assign spi_miso    = cs_on & w_sr[tx_idx];

    always_comb begin
        rx_next         = (bit_cnt == '0) ? '0 : slv_rx_char;
        rx_next[rx_idx] = mosi_sync[SYNC-1];
    end

    always_ff @(posedge S_SYSCLK or negedge arst_n) begin
        if (!arst_n) begin
            sck_sync      <= '0;
            cs_sync       <= '0;
            mosi_sync     <= '0;
            sck_prev      <= 1'b0;
            cs_on_q       <= 1'b0;
            done_d        <= 1'b0;
            slv_char_done <= 1'b0;
            bit_cnt       <= '0;
            tx_bit        <= '0;
        end else begin
            sck_sync      <= {sck_sync[SYNC-2:0], spi_sck};
            cs_sync       <= {cs_sync[SYNC-2:0], spi_cs};
            mosi_sync     <= {mosi_sync[SYNC-2:0], spi_mosi};
            sck_prev      <= sck_s;
            cs_on_q       <= cs_on;
            done_d        <= slv_char_done;
            slv_char_done <= sample_edge && (bit_cnt == char_len);
            if (!cs_on) begin
                bit_cnt <= '0;
                tx_bit  <= '0;
            end else begin
                if (sample_edge) begin
                    bit_cnt <= (bit_cnt == char_len) ? '0 : bit_cnt + 1'b1;
                end
                if (load) begin
                    tx_bit <= '0;
                end else if (shift_edge) begin
                    tx_bit <= tx_bit + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (load) begin
            w_sr <= s_wchar;
        end
        if (sample_edge) begin
            slv_rx_char <= rx_next;
        end
    end

endmodule

// File: spi_slave_model.sv
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_slave_model (
    input  logic                    S_SYSCLK,
    input  logic                    arst_n,
    input  logic                    enable,
    input  spi_mode_pkg::char_len_t char_len,
    input  logic                    slv_active,
    input  logic                    slv_char_done,
    input  spi_data_pkg::spi_char_t slv_rx_char,
    output spi_data_pkg::spi_char_t s_wchar,
    input  logic                    tx_wr,
    input  spi_data_pkg::tx_idx_t   tx_addr,
    input  spi_data_pkg::spi_word_t tx_wdata,
    output logic                    rx_word_valid,
    output spi_data_pkg::spi_word_t rx_word
);

    import spi_mode_pkg::*;
    import spi_data_pkg::*;

    localparam int LANE  = `SPI_LANE_BITS;
    localparam int HALF  = LANE / 2;
    localparam int IDX_W = $bits(tx_idx_t);

    spi_word_t        tx_tab [`SPI_TX_DEPTH];
    spi_word_t        tx_word;
    spi_word_t        rx_acc;
    spi_word_t        rx_merge;
    logic [IDX_W+1:0] tx_cnt;     // word index above lane index
    logic [1:0]       rx_idx;     // lane of next received char
    tx_idx_t          word_idx;
    logic             wide;
    logic             word_last;
    logic             rx_take;

    assign wide      = wide_lane(char_len);
    assign word_idx  = wide ? tx_cnt[IDX_W:1] : tx_cnt[IDX_W+1:2];
    assign tx_word   = tx_tab[word_idx];
    assign word_last = wide ? rx_idx[0] : (rx_idx == 2'd3);
    assign rx_take   = slv_char_done & slv_active;

    always_comb begin
        if (wide) begin
            s_wchar = tx_word[int'(tx_cnt[0]) * LANE +: LANE];
        end else begin
            s_wchar = {{(LANE - HALF){1'b0}}, tx_word[int'(tx_cnt[1:0]) * HALF +: HALF]};
        end
    end

    always_comb begin
        rx_merge = rx_acc;
        if (wide) begin
            rx_merge[int'(rx_idx[0]) * LANE +: LANE] = slv_rx_char;
        end else begin
            rx_merge[int'(rx_idx) * HALF +: HALF] = slv_rx_char[HALF-1:0];
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (tx_wr) begin
            tx_tab[tx_addr] <= tx_wdata;
        end
        if (rx_take) begin
            rx_acc <= rx_merge;
        end
        if (rx_take && word_last) begin
            rx_word <= rx_merge;
        end
    end

    always_ff @(posedge S_SYSCLK or negedge arst_n) begin
        if (!arst_n) begin
            tx_cnt        <= '0;
            rx_idx        <= '0;
            rx_word_valid <= 1'b0;
        end else begin
            rx_word_valid <= rx_take & word_last;
            if (!enable) begin
                tx_cnt <= '0;  // restart at entry 0, lane 0
            end else if (slv_char_done) begin
                tx_cnt <= tx_cnt + 1'b1;  // wraps through the table
            end
            if (!slv_active) begin
                rx_idx <= '0;  // partial word dropped
            end else if (slv_char_done) begin
                rx_idx <= word_last ? '0 : rx_idx + 1'b1;
            end
        end
    end

endmodule

// File: spi_loop_top.sv
`timescale 1ns/1ps

module spi_loop_top (
    input  logic                    S_SYSCLK,
    input  logic                    arst_n,
    input  logic                    enable,
    input  spi_mode_pkg::spi_mode_t mode,
    input  spi_mode_pkg::char_len_t char_len,
    input  logic                    m_start,
    input  logic                    m_hold,
    input  spi_data_pkg::spi_char_t m_tx_char,
    output logic                    m_busy,
    output logic                    m_done,
    output spi_data_pkg::spi_char_t m_rx_char,
    input  logic                    tx_wr,
    input  spi_data_pkg::tx_idx_t   tx_addr,
    input  spi_data_pkg::spi_word_t tx_wdata,
    output logic                    rx_word_valid,
    output spi_data_pkg::spi_word_t rx_word,
    output logic                    spi_sck,
    output logic                    spi_cs,
    output logic                    spi_mosi,
    output logic                    spi_miso
);

    import spi_data_pkg::*;

    spi_char_t s_wchar;        // next char from packer
    spi_char_t slv_rx_char;
    logic      slv_active;
    logic      slv_char_done;

    spi_master_char master_i (
        .S_SYSCLK  (S_SYSCLK),
        .arst_n    (arst_n),
        .mode      (mode),
        .char_len  (char_len),
        .m_start   (m_start),
        .m_hold    (m_hold),
        .m_tx_char (m_tx_char),
        .m_busy    (m_busy),
        .m_done    (m_done),
        .m_rx_char (m_rx_char),
        .spi_sck   (spi_sck),
        .spi_cs    (spi_cs),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso)
    );

    spi_slave_trx_char slave_i (
        .S_SYSCLK      (S_SYSCLK),
        .arst_n        (arst_n),
        .enable        (enable),
        .mode          (mode),
        .char_len      (char_len),
        .spi_cs        (spi_cs),
        .spi_sck       (spi_sck),
        .spi_mosi      (spi_mosi),
        .spi_miso      (spi_miso),
        .slv_active    (slv_active),
        .slv_char_done (slv_char_done),
        .s_wchar       (s_wchar),
        .slv_rx_char   (slv_rx_char)
    );

    spi_slave_model model_i (
        .S_SYSCLK      (S_SYSCLK),
        .arst_n        (arst_n),
        .enable        (enable),
        .char_len      (char_len),
        .slv_active    (slv_active),
        .slv_char_done (slv_char_done),
        .slv_rx_char   (slv_rx_char),
        .s_wchar       (s_wchar),
        .tx_wr         (tx_wr),
        .tx_addr       (tx_addr),
        .tx_wdata      (tx_wdata),
        .rx_word_valid (rx_word_valid),
        .rx_word       (rx_word)
    );

endmodule

// File: spi_loop_checker.sv
`timescale 1ns/1ps

module spi_loop_checker (
    input logic                    S_SYSCLK,
    input logic                    arst_n,
    input spi_mode_pkg::spi_mode_t mode,
    input logic                    m_start,
    input logic                    m_busy,
    input logic                    m_done,
    input logic                    rx_word_valid,
    input logic                    spi_sck,
    input logic                    spi_cs
);

    a_done_pulse: assert property (@(posedge S_SYSCLK) disable iff (!arst_n)
        m_done |=> !m_done)
        else $error("m_done stayed high for more than one cycle");

    a_word_pulse: assert property (@(posedge S_SYSCLK) disable iff (!arst_n)
        rx_word_valid |=> !rx_word_valid)
        else $error("rx_word_valid stayed high for more than one cycle");

    // cs at the cspol level means the bus is idle
    a_sck_idle: assert property (@(posedge S_SYSCLK) disable iff (!arst_n)
        (spi_cs == mode.cspol) |-> (spi_sck == mode.cpol))
        else $error("spi_sck left the idle level while chip select was inactive");

    a_start_idle: assert property (@(posedge S_SYSCLK) disable iff (!arst_n)
        m_start |-> !m_busy)
        else $error("m_start given while the master was busy");

endmodule

// File: tb_spi_loop.sv
`timescale 1ns/1ps
`include "spi_cfg.svh"

module tb_spi_loop;

    import spi_mode_pkg::*;
    import spi_data_pkg::*;

    localparam int LANE        = `SPI_LANE_BITS;
    localparam int WORD        = `SPI_WORD_BITS;
    localparam int DEPTH       = `SPI_TX_DEPTH;
    localparam int WAIT_CYCLES = 100 * `SPI_HALF_DIV;

    logic      S_SYSCLK;
    logic      arst_n;
    logic      enable;
    spi_mode_t mode;
    char_len_t char_len;
    logic      m_start;
    logic      m_hold;
    spi_char_t m_tx_char;
    logic      m_busy;
    logic      m_done;
    spi_char_t m_rx_char;
    logic      tx_wr;
    tx_idx_t   tx_addr;
    spi_word_t tx_wdata;
    logic      rx_word_valid;
    spi_word_t rx_word;
    logic      spi_sck;
    logic      spi_cs;
    logic      spi_mosi;
    logic      spi_miso;

    integer                  seed;
    logic [DEPTH*WORD-1:0]   tab_flat;     // copy of the slave table
    logic [4*LANE-1:0]       frame_chars;  // chars since the last word boundary
    int                      n_frame;
    int                      tx_count;     // slave transmit position
    spi_char_t               exp_char_q[$];
    spi_word_t               exp_word_q[$];

    spi_loop_top dut_i (
        .S_SYSCLK      (S_SYSCLK),
        .arst_n        (arst_n),
        .enable        (enable),
        .mode          (mode),
        .char_len      (char_len),
        .m_start       (m_start),
        .m_hold        (m_hold),
        .m_tx_char     (m_tx_char),
        .m_busy        (m_busy),
        .m_done        (m_done),
        .m_rx_char     (m_rx_char),
        .tx_wr         (tx_wr),
        .tx_addr       (tx_addr),
        .tx_wdata      (tx_wdata),
        .rx_word_valid (rx_word_valid),
        .rx_word       (rx_word),
        .spi_sck       (spi_sck),
        .spi_cs        (spi_cs),
        .spi_mosi      (spi_mosi),
        .spi_miso      (spi_miso)
    );

    bind spi_loop_top spi_loop_checker checker_i (
        .S_SYSCLK      (S_SYSCLK),
        .arst_n        (arst_n),
        .mode          (mode),
        .m_start       (m_start),
        .m_busy        (m_busy),
        .m_done        (m_done),
        .rx_word_valid (rx_word_valid),
        .spi_sck       (spi_sck),
        .spi_cs        (spi_cs)
    );

    always #50 S_SYSCLK = ~S_SYSCLK;

    function automatic spi_char_t len_mask(input char_len_t len);
        spi_char_t mask;
        mask = '0;
        for (int i = 0; i <= int'(len); i++)
            mask[i] = 1'b1;
        return mask;
    endfunction

    // slave answer: table entries in order, low lane first
    function automatic spi_char_t expect_tx_char(input logic [DEPTH*WORD-1:0] tab,
                                                 input int count, input char_len_t len);
        spi_word_t word;
        spi_char_t ch;
        if (len > 4'd7) begin
            word = tab[((count / 2) % DEPTH) * WORD +: WORD];
            ch   = word[(count % 2) * LANE +: LANE];
        end else begin
            word = tab[((count / 4) % DEPTH) * WORD +: WORD];
            ch   = {{(LANE / 2){1'b0}}, word[(count % 4) * (LANE / 2) +: LANE / 2]};
        end
        return ch & len_mask(len);
    endfunction

    // received chars fill the word from the low lane up
    function automatic spi_word_t expect_word(input logic [4*LANE-1:0] chars,
                                              input char_len_t len);
        spi_word_t word;
        if (len > 4'd7)
            word = {chars[31:16], chars[15:0]};
        else
            word = {chars[55:48], chars[39:32], chars[23:16], chars[7:0]};
        return word;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
                                $time, what, got, exp));
    endtask

    task automatic send_char(input spi_char_t ch, input logic hold);
        spi_char_t sent;
        spi_char_t reply;
        logic      prev_sck;
        logic      first_bit;
        logic      first_miso;
        int        edges;
        int        target;
        int        cyc;
        sent  = ch & len_mask(char_len);
        reply = expect_tx_char(tab_flat, tx_count, char_len);
        exp_char_q.push_back(reply);
        frame_chars[n_frame * LANE +: LANE] = sent;
        n_frame++;
        if (n_frame == ((char_len > 4'd7) ? 2 : 4)) begin
            exp_word_q.push_back(expect_word(frame_chars, char_len));
            n_frame = 0;
        end
        m_tx_char = ch;  // bits above char_len are not sent
        m_hold    = hold;
        m_start   = 1'b1;
        prev_sck  = spi_sck;
        @(negedge S_SYSCLK);
        m_start    = 1'b0;
        edges      = 0;
        target     = mode.cpha ? 2 : 1;  // first sampling edge
        first_bit  = 1'bx;
        first_miso = 1'bx;
        for (cyc = 0; cyc < WAIT_CYCLES && !m_done; cyc++) begin
            if (spi_sck !== prev_sck) begin
                edges++;
                if (edges == target) begin
                    first_bit  = spi_mosi;
                    first_miso = spi_miso;
                end
            end
            prev_sck = spi_sck;
            @(negedge S_SYSCLK);
        end
        if (!m_done)
            abort_run($sformatf("timeout at %0t ns: m_done never came", $time));
        check_value("first mosi bit", first_bit, mode.rev ? sent[0] : sent[char_len]);
        check_value("first miso bit", first_miso, mode.rev ? reply[0] : reply[char_len]);
        tx_count++;
        if (!hold) begin
            n_frame = 0;  // slave drops a partial word
            repeat (3) @(negedge S_SYSCLK);
        end
    endtask

    task automatic send_frame(input int n);
        for (int k = 0; k < n; k++)
            send_char(spi_char_t'($random(seed)), k != n - 1);
    endtask

    task automatic load_table();
        for (int i = 0; i < DEPTH; i++) begin
            tx_wdata = $random(seed);
            tx_addr  = tx_idx_t'(i);
            tx_wr    = 1'b1;
            tab_flat[i * WORD +: WORD] = tx_wdata;
            @(negedge S_SYSCLK);
        end
        tx_wr = 1'b0;
    endtask

    // enable low also restarts the slave at entry 0, lane 0
    task automatic set_mode(input spi_mode_t m, input char_len_t len);
        enable = 1'b0;
        @(negedge S_SYSCLK);
        mode     = m;
        char_len = len;
        repeat (4) @(negedge S_SYSCLK);
        enable   = 1'b1;
        tx_count = 0;
        n_frame  = 0;
        @(negedge S_SYSCLK);
    endtask

    task automatic wait_words_drained();
        int cyc;
        for (cyc = 0; cyc < WAIT_CYCLES && exp_word_q.size() != 0; cyc++)
            @(negedge S_SYSCLK);
        if (exp_word_q.size() != 0)
            abort_run($sformatf("timeout at %0t ns: rx_word_valid never came", $time));
    endtask

    always @(negedge S_SYSCLK) begin
        if (arst_n && m_done) begin
            if (exp_char_q.size() == 0)
                abort_run("m_done pulsed with no character outstanding");
            else
                check_value("m_rx_char", m_rx_char, exp_char_q.pop_front());
        end
        if (arst_n && rx_word_valid) begin
            if (exp_word_q.size() == 0)
                abort_run("rx_word_valid pulsed when no word was expected");
            else
                check_value("rx_word", rx_word, exp_word_q.pop_front());
        end
    end

    initial begin
        seed        = 32'hf79a_8590;
        S_SYSCLK    = 1'b0;
        arst_n      = 1'b0;
        enable      = 1'b0;
        mode        = '{cpol: 1'b0, cpha: 1'b0, cspol: 1'b1, rev: 1'b0};
        char_len    = 4'd15;
        m_start     = 1'b0;
        m_hold      = 1'b0;
        m_tx_char   = '0;
        tx_wr       = 1'b0;
        tx_addr     = '0;
        tx_wdata    = '0;
        tab_flat    = '0;
        frame_chars = '0;
        n_frame     = 0;
        tx_count    = 0;
        repeat (2) @(negedge S_SYSCLK);
        arst_n = 1'b1;
        check_value("m_busy after reset", m_busy, 0);
        check_value("spi_cs after reset", spi_cs, 1);
        check_value("spi_sck after reset", spi_sck, 0);
        enable = 1'b1;
        load_table();
        send_frame(4);  // mode 0, 16-bit
        send_frame(1);  // partial word
        send_frame(2);
        repeat (3)
            send_frame(4);  // runs past the end of the table
        set_mode('{cpol: 1'b0, cpha: 1'b0, cspol: 1'b1, rev: 1'b0}, 4'd15);
        send_frame(2);
        set_mode('{cpol: 1'b0, cpha: 1'b0, cspol: 1'b1, rev: 1'b1}, 4'd15);
        send_frame(2);
        set_mode('{cpol: 1'b1, cpha: 1'b1, cspol: 1'b1, rev: 1'b0}, 4'd7);
        send_frame(8);
        set_mode('{cpol: 1'b0, cpha: 1'b1, cspol: 1'b1, rev: 1'b0}, 4'd5);
        send_frame(4);  // 6-bit chars in 8-bit lanes
        set_mode('{cpol: 1'b0, cpha: 1'b0, cspol: 1'b0, rev: 1'b0}, 4'd15);
        check_value("idle spi_cs, active high", spi_cs, 0);
        send_frame(4);
        wait_words_drained();
        if (exp_char_q.size() == 0 && exp_word_q.size() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run("some expected m_done events never came");
        end
    end

endmodule

// File: list.f
+incdir+.
spi_mode_pkg.sv
spi_data_pkg.sv
spi_master_char.sv
spi_slave_trx_char.sv
spi_slave_model.sv
spi_loop_top.sv
spi_loop_checker.sv
tb_spi_loop.sv

// File: run.sh
#!/usr/bin/env bash
# build the loop-back testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_spi_loop \
    -o sim_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
